/* mhu_macros.svh */
// fixed geometry; ways, sets and words per block must be powers of two with matching LG values
`ifndef MHU_MACROS_SVH
`define MHU_MACROS_SVH

// cache geometry
`define MHU_WAYS 4
`define MHU_LG_WAYS 2
`define MHU_SETS 16
`define MHU_LG_SETS 4
`define MHU_BLOCK_WORDS 4
`define MHU_LG_BLOCK_WORDS 2

// word and byte address
`define MHU_DATA_WIDTH 32
`define MHU_BYTE_SEL_WIDTH 2
`define MHU_ADDR_WIDTH 16

// address layout, high to low: tag, index, word, byte
`define MHU_WORD_LSB (`MHU_BYTE_SEL_WIDTH)
`define MHU_INDEX_LSB (`MHU_WORD_LSB + `MHU_LG_BLOCK_WORDS)
`define MHU_TAG_LSB (`MHU_INDEX_LSB + `MHU_LG_SETS)
`define MHU_TAG_WIDTH (`MHU_ADDR_WIDTH - `MHU_TAG_LSB)

`endif

/* mhu_pkg.sv */
// plain vector types only, all sized from mhu_macros.svh
`include "mhu_macros.svh"

package mhu_pkg;

  // way number and one-hot style per-way flags
  typedef logic [`MHU_LG_WAYS-1:0] way_id_t;
  typedef logic [`MHU_WAYS-1:0] way_vec_t;

  // address fields
  typedef logic [`MHU_LG_SETS-1:0] set_index_t;
  typedef logic [`MHU_TAG_WIDTH-1:0] tag_t;
  typedef logic [`MHU_LG_BLOCK_WORDS-1:0] word_sel_t;

  // full byte address and one data word
  typedef logic [`MHU_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`MHU_DATA_WIDTH-1:0] data_t;

endpackage

/* replacement_select.sv */
// assumes at least one way is unlocked; tag and status inputs must be valid while capture_i is high
`timescale 1ns/1ps
`include "mhu_macros.svh"

module replacement_select (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   capture_i,
  input  mhu_pkg::way_vec_t                      way_valid_i,
  input  mhu_pkg::way_vec_t                      way_lock_i,
  input  mhu_pkg::way_vec_t                      way_dirty_i,
  input  mhu_pkg::tag_t [`MHU_WAYS-1:0]          way_tags_i,
  input  mhu_pkg::way_id_t                       lru_way_i,
  output mhu_pkg::way_id_t                       victim_way_o,
  output logic                                   evict_o,
  output mhu_pkg::tag_t                          evict_tag_o
);

  logic [`MHU_LG_WAYS:0] invalid_pick;
  logic [`MHU_LG_WAYS:0] unlocked_pick;
  mhu_pkg::way_id_t      chosen_way;

  // lowest set bit, found flag on top
  function automatic logic [`MHU_LG_WAYS:0] lowest_way(input mhu_pkg::way_vec_t vec);
    logic [`MHU_LG_WAYS:0] result;
    result = '0;
    for (int i = `MHU_WAYS - 1; i >= 0; i--) begin
      if (vec[i]) begin
        result = {1'b1, mhu_pkg::way_id_t'(i)};
      end
    end
    return result;
  endfunction

  assign invalid_pick  = lowest_way(~way_valid_i & ~way_lock_i);
  assign unlocked_pick = lowest_way(~way_lock_i);

  // invalid first, then LRU, then any unlocked way
  assign chosen_way = invalid_pick[`MHU_LG_WAYS] ? invalid_pick[`MHU_LG_WAYS-1:0]
                    : (way_lock_i[lru_way_i] ? unlocked_pick[`MHU_LG_WAYS-1:0] : lru_way_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      victim_way_o <= '0;
      evict_o      <= 1'b0;
    end else if (capture_i) begin
      victim_way_o <= chosen_way;
      evict_o      <= way_valid_i[chosen_way] & way_dirty_i[chosen_way];
    end
  end

  // victim tag only matters when evict_o is set
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      evict_tag_o <= way_tags_i[chosen_way];
    end
  end

endmodule

/* secondary_match.sv */
// one block tracked at a time; is_secondary_o stays low until the first load after reset
`timescale 1ns/1ps
`include "mhu_macros.svh"

module secondary_match (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                load_i,
  input  mhu_pkg::way_id_t    load_way_i,
  input  mhu_pkg::addr_t      load_addr_i,
  input  mhu_pkg::addr_t      head_addr_i,
  output logic                is_secondary_o,
  output mhu_pkg::way_id_t    cur_way_o,
  output mhu_pkg::set_index_t cur_index_o,
  output mhu_pkg::tag_t       cur_tag_o
);

  logic                cur_v_r;
  mhu_pkg::set_index_t head_index;
  mhu_pkg::tag_t       head_tag;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cur_v_r <= 1'b0;
    end else if (load_i) begin
      cur_v_r <= 1'b1;
    end
  end

  // block being refilled
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      cur_way_o   <= load_way_i;
      cur_index_o <= load_addr_i[`MHU_INDEX_LSB +: `MHU_LG_SETS];
      cur_tag_o   <= load_addr_i[`MHU_TAG_LSB +: `MHU_TAG_WIDTH];
    end
  end

  assign head_index = head_addr_i[`MHU_INDEX_LSB +: `MHU_LG_SETS];
  assign head_tag   = head_addr_i[`MHU_TAG_LSB +: `MHU_TAG_WIDTH];

  assign is_secondary_o = cur_v_r & (head_index == cur_index_o) & (head_tag == cur_tag_o);

endmodule

/* miss_sequencer.sv */
// one primary miss in flight; every access is a full word and the DMA refills the whole block
`timescale 1ns/1ps
`include "mhu_macros.svh"

module miss_sequencer (
  input  logic                clk_i,
  input  logic                reset_i,
  // miss FIFO head
  input  logic                miss_v_i,
  input  logic                miss_write_i,
  input  logic                miss_block_load_i,
  input  mhu_pkg::addr_t      miss_addr_i,
  input  mhu_pkg::data_t      miss_data_i,
  output logic                miss_yumi_o,
  // tag and status read
  output logic                tag_read_v_o,
  output mhu_pkg::set_index_t tag_read_index_o,
  // replacement and block tracking
  output logic                capture_o,
  output logic                load_o,
  input  mhu_pkg::way_id_t    victim_way_i,
  input  logic                evict_i,
  input  mhu_pkg::tag_t       evict_tag_i,
  input  logic                is_secondary_i,
  input  mhu_pkg::way_id_t    cur_way_i,
  input  mhu_pkg::set_index_t cur_index_i,
  input  mhu_pkg::tag_t       cur_tag_i,
  // DMA
  output logic                dma_cmd_v_o,
  output mhu_pkg::way_id_t    dma_way_o,
  output mhu_pkg::set_index_t dma_index_o,
  output mhu_pkg::tag_t       dma_refill_tag_o,
  output logic                dma_evict_o,
  output mhu_pkg::tag_t       dma_evict_tag_o,
  input  logic                dma_cmd_ready_i,
  input  logic                dma_done_i,
  output logic                dma_ack_o,
  // data memory
  output logic                dm_v_o,
  output logic                dm_write_o,
  output mhu_pkg::way_id_t    dm_way_o,
  output mhu_pkg::set_index_t dm_index_o,
  output mhu_pkg::word_sel_t  dm_word_o,
  output mhu_pkg::data_t      dm_data_o,
  input  logic                dm_ready_i,
  // tag and status write
  output logic                tag_write_v_o,
  output mhu_pkg::way_id_t    tag_write_way_o,
  output mhu_pkg::set_index_t tag_write_index_o,
  output mhu_pkg::tag_t       tag_write_tag_o,
  output logic                tag_write_dirty_o,
  output logic                idle_o
);

  localparam logic [2:0] IDLE     = 3'd0;
  localparam logic [2:0] VICTIM   = 3'd1;
  localparam logic [2:0] SEND_DMA = 3'd2;
  localparam logic [2:0] WAIT_DMA = 3'd3;
  localparam logic [2:0] DRAIN    = 3'd4;
  localparam logic [2:0] UPDATE   = 3'd5;

  logic [2:0]         state_r;
  logic [2:0]         state_n;
  mhu_pkg::word_sel_t word_cnt_r;
  logic               last_word;
  logic               dm_xfer;
  logic               dirty_r;

  always_comb begin
    state_n       = state_r;
    tag_read_v_o  = 1'b0;
    capture_o     = 1'b0;
    dma_cmd_v_o   = 1'b0;
    load_o        = 1'b0;
    dma_ack_o     = 1'b0;
    dm_v_o        = 1'b0;
    tag_write_v_o = 1'b0;
    case (state_r)
      IDLE: begin
        tag_read_v_o = miss_v_i;
        if (miss_v_i) begin
          state_n = VICTIM;
        end
      end
      VICTIM: begin
        // tag and status read data is on the inputs now
        capture_o = 1'b1;
        state_n   = SEND_DMA;
      end
      SEND_DMA: begin
        dma_cmd_v_o = 1'b1;
        load_o      = dma_cmd_ready_i;
        if (dma_cmd_ready_i) begin
          state_n = WAIT_DMA;
        end
      end
      WAIT_DMA: begin
        dma_ack_o = dma_done_i;
        if (dma_done_i) begin
          state_n = DRAIN;
        end
      end
      DRAIN: begin
        dm_v_o = miss_v_i & is_secondary_i;
        // empty FIFO or a different block ends the drain
        if (!(miss_v_i && is_secondary_i)) begin
          state_n = UPDATE;
        end
      end
      UPDATE: begin
        tag_write_v_o = 1'b1;
        state_n       = IDLE;
      end
      default: begin
        state_n = IDLE;
      end
    endcase
  end

  assign last_word   = (word_cnt_r == mhu_pkg::word_sel_t'(`MHU_BLOCK_WORDS - 1));
  assign dm_xfer     = dm_v_o & dm_ready_i;
  assign miss_yumi_o = dm_xfer & (~miss_block_load_i | last_word);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= IDLE;
      word_cnt_r <= '0;
      dirty_r    <= 1'b0;
    end else begin
      state_r <= state_n;
      if (dm_xfer && miss_block_load_i) begin
        word_cnt_r <= last_word ? '0 : word_cnt_r + mhu_pkg::word_sel_t'(1);
      end
      if (load_o) begin
        dirty_r <= 1'b0;
      end else if (dm_xfer && miss_write_i && !miss_block_load_i) begin
        dirty_r <= 1'b1;
      end
    end
  end

  assign tag_read_index_o = miss_addr_i[`MHU_INDEX_LSB +: `MHU_LG_SETS];

  // command fields hold while the head is not popped
  assign dma_way_o        = victim_way_i;
  assign dma_index_o      = miss_addr_i[`MHU_INDEX_LSB +: `MHU_LG_SETS];
  assign dma_refill_tag_o = miss_addr_i[`MHU_TAG_LSB +: `MHU_TAG_WIDTH];
  assign dma_evict_o      = evict_i;
  assign dma_evict_tag_o  = evict_tag_i;

  // block loads walk the words of the block as reads
  assign dm_write_o = miss_write_i & ~miss_block_load_i;
  assign dm_way_o   = cur_way_i;
  assign dm_index_o = cur_index_i;
  assign dm_word_o  = miss_block_load_i ? word_cnt_r
                    : miss_addr_i[`MHU_WORD_LSB +: `MHU_LG_BLOCK_WORDS];
  assign dm_data_o  = miss_data_i;

  assign tag_write_way_o   = cur_way_i;
  assign tag_write_index_o = cur_index_i;
  assign tag_write_tag_o   = cur_tag_i;
  assign tag_write_dirty_o = dirty_r;

  assign idle_o = (state_r == IDLE) & ~miss_v_i;

endmodule

/* miss_handling_unit.sv */
// tag and status memories live outside; read data must follow tag_read_v_o by one cycle and hold
`timescale 1ns/1ps
`include "mhu_macros.svh"

module miss_handling_unit (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          miss_v_i,
  input  logic                          miss_write_i,
  input  logic                          miss_block_load_i,
  input  mhu_pkg::addr_t                miss_addr_i,
  input  mhu_pkg::data_t                miss_data_i,
  output logic                          miss_yumi_o,
  output logic                          tag_read_v_o,
  output mhu_pkg::set_index_t           tag_read_index_o,
  input  mhu_pkg::way_vec_t             way_valid_i,
  input  mhu_pkg::way_vec_t             way_lock_i,
  input  mhu_pkg::way_vec_t             way_dirty_i,
  input  mhu_pkg::tag_t [`MHU_WAYS-1:0] way_tags_i,
  input  mhu_pkg::way_id_t              lru_way_i,
  output logic                          dma_cmd_v_o,
  output mhu_pkg::way_id_t              dma_way_o,
  output mhu_pkg::set_index_t           dma_index_o,
  output mhu_pkg::tag_t                 dma_refill_tag_o,
  output logic                          dma_evict_o,
  output mhu_pkg::tag_t                 dma_evict_tag_o,
  input  logic                          dma_cmd_ready_i,
  input  logic                          dma_done_i,
  output logic                          dma_ack_o,
  output logic                          dm_v_o,
  output logic                          dm_write_o,
  output mhu_pkg::way_id_t              dm_way_o,
  output mhu_pkg::set_index_t           dm_index_o,
  output mhu_pkg::word_sel_t            dm_word_o,
  output mhu_pkg::data_t                dm_data_o,
  input  logic                          dm_ready_i,
  output logic                          tag_write_v_o,
  output mhu_pkg::way_id_t              tag_write_way_o,
  output mhu_pkg::set_index_t           tag_write_index_o,
  output mhu_pkg::tag_t                 tag_write_tag_o,
  output logic                          tag_write_dirty_o,
  output logic                          idle_o
);

  logic                capture;
  logic                load;
  mhu_pkg::way_id_t    victim_way;
  logic                evict;
  mhu_pkg::tag_t       evict_tag;
  logic                is_secondary;
  mhu_pkg::way_id_t    cur_way;
  mhu_pkg::set_index_t cur_index;
  mhu_pkg::tag_t       cur_tag;

  replacement_select i_replacement_select (
    .clk_i(clk_i), .reset_i(reset_i), .capture_i(capture),
    .way_valid_i(way_valid_i), .way_lock_i(way_lock_i), .way_dirty_i(way_dirty_i),
    .way_tags_i(way_tags_i), .lru_way_i(lru_way_i),
    .victim_way_o(victim_way), .evict_o(evict), .evict_tag_o(evict_tag)
  );

  // head address doubles as the load address when the command is taken
  secondary_match i_secondary_match (
    .clk_i(clk_i), .reset_i(reset_i), .load_i(load), .load_way_i(victim_way),
    .load_addr_i(miss_addr_i), .head_addr_i(miss_addr_i), .is_secondary_o(is_secondary),
    .cur_way_o(cur_way), .cur_index_o(cur_index), .cur_tag_o(cur_tag)
  );

  miss_sequencer i_miss_sequencer (
    .clk_i(clk_i), .reset_i(reset_i),
    .miss_v_i(miss_v_i), .miss_write_i(miss_write_i), .miss_block_load_i(miss_block_load_i),
    .miss_addr_i(miss_addr_i), .miss_data_i(miss_data_i), .miss_yumi_o(miss_yumi_o),
    .tag_read_v_o(tag_read_v_o), .tag_read_index_o(tag_read_index_o),
    .capture_o(capture), .load_o(load),
    .victim_way_i(victim_way), .evict_i(evict), .evict_tag_i(evict_tag),
    .is_secondary_i(is_secondary), .cur_way_i(cur_way), .cur_index_i(cur_index),
    .cur_tag_i(cur_tag),
    .dma_cmd_v_o(dma_cmd_v_o), .dma_way_o(dma_way_o), .dma_index_o(dma_index_o),
    .dma_refill_tag_o(dma_refill_tag_o), .dma_evict_o(dma_evict_o),
    .dma_evict_tag_o(dma_evict_tag_o), .dma_cmd_ready_i(dma_cmd_ready_i),
    .dma_done_i(dma_done_i), .dma_ack_o(dma_ack_o),
    .dm_v_o(dm_v_o), .dm_write_o(dm_write_o), .dm_way_o(dm_way_o), .dm_index_o(dm_index_o),
    .dm_word_o(dm_word_o), .dm_data_o(dm_data_o), .dm_ready_i(dm_ready_i),
    .tag_write_v_o(tag_write_v_o), .tag_write_way_o(tag_write_way_o),
    .tag_write_index_o(tag_write_index_o), .tag_write_tag_o(tag_write_tag_o),
    .tag_write_dirty_o(tag_write_dirty_o), .idle_o(idle_o)
  );

endmodule

/* mhu_asserts.sv */
// bound by port name into miss_handling_unit; needs concurrent assertion support
`timescale 1ns/1ps

module mhu_asserts (
  input logic                clk_i,
  input logic                reset_i,
  input logic                miss_yumi_o,
  input logic                dma_cmd_v_o,
  input logic                dma_cmd_ready_i,
  input mhu_pkg::way_id_t    dma_way_o,
  input mhu_pkg::set_index_t dma_index_o,
  input mhu_pkg::tag_t       dma_refill_tag_o,
  input logic                dma_evict_o,
  input mhu_pkg::tag_t       dma_evict_tag_o,
  input logic                dma_done_i,
  input logic                dma_ack_o,
  input logic                dm_v_o,
  input logic                dm_ready_i,
  input logic                dm_write_o,
  input mhu_pkg::way_id_t    dm_way_o,
  input mhu_pkg::set_index_t dm_index_o,
  input mhu_pkg::word_sel_t  dm_word_o,
  input mhu_pkg::data_t      dm_data_o,
  input logic                tag_write_v_o
);

  int fail_count = 0;

  // command held until taken
  dma_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_cmd_v_o && !dma_cmd_ready_i |=> dma_cmd_v_o
      && $stable({dma_way_o, dma_index_o, dma_refill_tag_o, dma_evict_o, dma_evict_tag_o}))
    else begin
      fail_count++;
      $error("dma command dropped or changed before it was taken");
    end

  dm_packet_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    dm_v_o && !dm_ready_i |=> dm_v_o
      && $stable({dm_write_o, dm_way_o, dm_index_o, dm_word_o, dm_data_o}))
    else begin
      fail_count++;
      $error("data memory packet dropped or changed under back-pressure");
    end

  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !(dma_cmd_v_o || dm_v_o || tag_write_v_o || dma_ack_o || miss_yumi_o))
    else begin
      fail_count++;
      $error("output active in the cycle after reset");
    end

  ack_with_done: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_ack_o |-> dma_done_i)
    else begin
      fail_count++;
      $error("dma ack without dma done");
    end

endmodule

bind miss_handling_unit mhu_asserts i_mhu_asserts (.*);

/* tb_miss_handling_unit.sv */
// random miss traffic from a fixed seed; tag memory, miss FIFO and DMA are modelled here
`timescale 1ns/1ps
`include "mhu_macros.svh"

module tb_miss_handling_unit;

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_TESTS       = 8;
  localparam int MAX_MISSES      = 12;
  localparam int CYCLES_PER_MISS = 64;
  localparam int WATCHDOG_NS     = (NUM_TESTS * MAX_MISSES * CYCLES_PER_MISS + 200) * CLK_PERIOD;

  // expected FSM position of the DUT
  localparam int M_IDLE   = 0;
  localparam int M_VICTIM = 1;
  localparam int M_SEND   = 2;
  localparam int M_WAIT   = 3;
  localparam int M_DRAIN  = 4;
  localparam int M_UPDATE = 5;

  logic                          clk_i;
  logic                          reset_i;
  logic                          miss_v_i;
  logic                          miss_write_i;
  logic                          miss_block_load_i;
  mhu_pkg::addr_t                miss_addr_i;
  mhu_pkg::data_t                miss_data_i;
  logic                          miss_yumi_o;
  logic                          tag_read_v_o;
  mhu_pkg::set_index_t           tag_read_index_o;
  mhu_pkg::way_vec_t             way_valid_i;
  mhu_pkg::way_vec_t             way_lock_i;
  mhu_pkg::way_vec_t             way_dirty_i;
  mhu_pkg::tag_t [`MHU_WAYS-1:0] way_tags_i;
  mhu_pkg::way_id_t              lru_way_i;
  logic                          dma_cmd_v_o;
  mhu_pkg::way_id_t              dma_way_o;
  mhu_pkg::set_index_t           dma_index_o;
  mhu_pkg::tag_t                 dma_refill_tag_o;
  logic                          dma_evict_o;
  mhu_pkg::tag_t                 dma_evict_tag_o;
  logic                          dma_cmd_ready_i;
  logic                          dma_done_i;
  logic                          dma_ack_o;
  logic                          dm_v_o;
  logic                          dm_write_o;
  mhu_pkg::way_id_t              dm_way_o;
  mhu_pkg::set_index_t           dm_index_o;
  mhu_pkg::word_sel_t            dm_word_o;
  mhu_pkg::data_t                dm_data_o;
  logic                          dm_ready_i;
  logic                          tag_write_v_o;
  mhu_pkg::way_id_t              tag_write_way_o;
  mhu_pkg::set_index_t           tag_write_index_o;
  mhu_pkg::tag_t                 tag_write_tag_o;
  logic                          tag_write_dirty_o;
  logic                          idle_o;

  logic [31:0]                   rng;
  int                            errors;
  int                            checks;
  int                            packets;
  int                            phase;
  int                            dma_cnt;
  int                            bl_word;
  int                            rd_set;
  mhu_pkg::way_id_t              exp_way;
  mhu_pkg::set_index_t           cur_index;
  mhu_pkg::tag_t                 cur_tag;
  logic                          exp_dirty;

  // miss FIFO, head at index 0
  logic                          q_write [$];
  logic                          q_bl [$];
  mhu_pkg::addr_t                q_addr [$];
  mhu_pkg::data_t                q_data [$];

  // tag and status memory
  mhu_pkg::way_vec_t             mem_valid [`MHU_SETS];
  mhu_pkg::way_vec_t             mem_lock [`MHU_SETS];
  mhu_pkg::way_vec_t             mem_dirty [`MHU_SETS];
  mhu_pkg::tag_t [`MHU_WAYS-1:0] mem_tags [`MHU_SETS];
  mhu_pkg::way_id_t              mem_lru [`MHU_SETS];

  miss_handling_unit i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired, the DUT stopped making progress");
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // invalid unlocked first, then LRU when unlocked, then first unlocked
  function automatic mhu_pkg::way_id_t pick_victim(input int s);
    for (int w = 0; w < `MHU_WAYS; w++) begin
      if (!mem_valid[s][w] && !mem_lock[s][w]) begin
        return mhu_pkg::way_id_t'(w);
      end
    end
    if (!mem_lock[s][mem_lru[s]]) begin
      return mem_lru[s];
    end
    for (int w = 0; w < `MHU_WAYS; w++) begin
      if (!mem_lock[s][w]) begin
        return mhu_pkg::way_id_t'(w);
      end
    end
    return '0;
  endfunction

  function automatic logic in_block(input mhu_pkg::addr_t a);
    return (a[`MHU_INDEX_LSB +: `MHU_LG_SETS] == cur_index)
        && (a[`MHU_TAG_LSB +: `MHU_TAG_WIDTH] == cur_tag);
  endfunction

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic fill_queue(input int n);
    mhu_pkg::addr_t a;
    logic [31:0]    r;
    a = '0;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      // small tag range, and most entries stay in the previous block
      if (i == 0 || r[2:0] < 3) begin
        a[`MHU_TAG_LSB +: `MHU_TAG_WIDTH]   = mhu_pkg::tag_t'(r[10:8]);
        a[`MHU_INDEX_LSB +: `MHU_LG_SETS] = r[15:12];
      end
      a[`MHU_WORD_LSB +: `MHU_LG_BLOCK_WORDS] = r[17:16];
      q_bl.push_back(r[20:18] == 3'd0);
      q_write.push_back(r[20:18] != 3'd0 && r[21]);
      q_addr.push_back(a);
      q_data.push_back(next_rand());
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = next_rand();
    miss_v_i = q_addr.size() > 0;
    if (miss_v_i) begin
      miss_write_i      = q_write[0];
      miss_block_load_i = q_bl[0];
      miss_addr_i       = q_addr[0];
      miss_data_i       = q_data[0];
    end
    dm_ready_i      = r[1:0] != 2'd0;
    dma_cmd_ready_i = r[2];
    dma_done_i      = phase == M_WAIT && dma_cnt == 0;
    // read data follows the read by one cycle, then holds
    if (phase == M_VICTIM) begin
      way_valid_i = mem_valid[rd_set];
      way_lock_i  = mem_lock[rd_set];
      way_dirty_i = mem_dirty[rd_set];
      way_tags_i  = mem_tags[rd_set];
      lru_way_i   = mem_lru[rd_set];
    end
  endtask

  task automatic check_packet(input logic exp_yumi);
    expect_value("dm_way_o", dm_way_o, exp_way);
    expect_value("dm_index_o", dm_index_o, cur_index);
    expect_value("dm_write_o", dm_write_o, q_write[0] && !q_bl[0]);
    if (q_bl[0]) begin
      expect_value("dm_word_o", dm_word_o, bl_word);
      bl_word = (bl_word + 1) % `MHU_BLOCK_WORDS;
    end else begin
      expect_value("dm_word_o", dm_word_o, q_addr[0][`MHU_WORD_LSB +: `MHU_LG_BLOCK_WORDS]);
      expect_value("dm_data_o", dm_data_o, q_data[0]);
      if (q_write[0]) begin
        exp_dirty = 1'b1;
      end
    end
    packets++;
    if (exp_yumi) begin
      void'(q_write.pop_front());
      void'(q_bl.pop_front());
      void'(q_addr.pop_front());
      void'(q_data.pop_front());
    end
  endtask

  task automatic check_cycle();
    logic head_v;
    logic exp_dm;
    logic exp_yumi;
    head_v   = q_addr.size() > 0;
    exp_dm   = phase == M_DRAIN && head_v && in_block(q_addr[0]);
    exp_yumi = exp_dm && dm_ready_i && (!q_bl[0] || bl_word == `MHU_BLOCK_WORDS - 1);
    expect_value("tag_read_v_o", tag_read_v_o, phase == M_IDLE && head_v);
    expect_value("dma_cmd_v_o", dma_cmd_v_o, phase == M_SEND);
    expect_value("dma_ack_o", dma_ack_o, phase == M_WAIT && dma_done_i);
    expect_value("dm_v_o", dm_v_o, exp_dm);
    expect_value("miss_yumi_o", miss_yumi_o, exp_yumi);
    expect_value("tag_write_v_o", tag_write_v_o, phase == M_UPDATE);
    expect_value("idle_o", idle_o, phase == M_IDLE && !head_v);
    case (phase)
      M_IDLE: if (head_v) begin
        rd_set = q_addr[0][`MHU_INDEX_LSB +: `MHU_LG_SETS];
        expect_value("tag_read_index_o", tag_read_index_o, rd_set);
        phase = M_VICTIM;
      end
      M_VICTIM: phase = M_SEND;
      M_SEND: if (dma_cmd_ready_i) begin
        exp_way   = pick_victim(rd_set);
        cur_index = q_addr[0][`MHU_INDEX_LSB +: `MHU_LG_SETS];
        cur_tag   = q_addr[0][`MHU_TAG_LSB +: `MHU_TAG_WIDTH];
        expect_value("dma_way_o", dma_way_o, exp_way);
        expect_value("dma_index_o", dma_index_o, cur_index);
        expect_value("dma_refill_tag_o", dma_refill_tag_o, cur_tag);
        expect_value("dma_evict_o", dma_evict_o,
                     mem_valid[rd_set][exp_way] && mem_dirty[rd_set][exp_way]);
        if (mem_valid[rd_set][exp_way] && mem_dirty[rd_set][exp_way]) begin
          expect_value("dma_evict_tag_o", dma_evict_tag_o, mem_tags[rd_set][exp_way]);
        end
        exp_dirty = 1'b0;
        dma_cnt   = next_rand() & 32'h7;
        phase     = M_WAIT;
      end
      M_WAIT: begin
        if (dma_done_i) begin
          phase = M_DRAIN;
        end else begin
          dma_cnt--;
        end
      end
      M_DRAIN: begin
        if (!exp_dm) begin
          phase = M_UPDATE;
        end else if (dm_ready_i) begin
          check_packet(exp_yumi);
        end
      end
      default: begin
        expect_value("tag_write_way_o", tag_write_way_o, exp_way);
        expect_value("tag_write_index_o", tag_write_index_o, cur_index);
        expect_value("tag_write_tag_o", tag_write_tag_o, cur_tag);
        expect_value("tag_write_dirty_o", tag_write_dirty_o, exp_dirty);
        mem_valid[cur_index][exp_way] = 1'b1;
        mem_dirty[cur_index][exp_way] = exp_dirty;
        mem_tags[cur_index][exp_way]  = cur_tag;
        mem_lru[cur_index]            = exp_way + mhu_pkg::way_id_t'(1);
        phase = M_IDLE;
      end
    endcase
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    drive_inputs();
    #(CLK_PERIOD / 4);
    check_cycle();
  endtask

  initial begin
    logic [31:0] r;
    int          n;
    int          err_before;
    int          pkt_before;
    int          total_errors;
    rng               = 32'hd9ca;
    errors            = 0;
    checks            = 0;
    packets           = 0;
    phase             = M_IDLE;
    dma_cnt           = 0;
    bl_word           = 0;
    rd_set            = 0;
    reset_i           = 1'b1;
    miss_v_i          = 1'b0;
    miss_write_i      = 1'b0;
    miss_block_load_i = 1'b0;
    miss_addr_i       = '0;
    miss_data_i       = '0;
    way_valid_i       = '0;
    way_lock_i        = '0;
    way_dirty_i       = '0;
    way_tags_i        = '0;
    lru_way_i         = '0;
    dma_cmd_ready_i   = 1'b0;
    dma_done_i        = 1'b0;
    dm_ready_i        = 1'b0;
    for (int s = 0; s < `MHU_SETS; s++) begin
      r            = next_rand();
      mem_valid[s] = r[3:0];
      mem_dirty[s] = r[7:4];
      mem_lock[s]  = r[11:8] & r[15:12];
      mem_lru[s]   = r[17:16];
      mem_tags[s]  = next_rand();
      // keep one way unlocked
      if (&mem_lock[s]) begin
        mem_lock[s][r[19:18]] = 1'b0;
      end
    end
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      n          = 4 + (next_rand() % (MAX_MISSES - 3));
      err_before = errors;
      pkt_before = packets;
      fill_queue(n);
      do begin
        run_cycle();
      end while (q_addr.size() > 0 || phase != M_IDLE);
      // one more cycle to see idle_o with an empty FIFO
      run_cycle();
      $display("test %0d: %0d misses, %0d packets, %0d errors", t, n,
               packets - pkt_before, errors - err_before);
    end
    total_errors = errors + i_dut.i_mhu_asserts.fail_count;
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+.
mhu_pkg.sv
replacement_select.sv
secondary_match.sv
miss_sequencer.sv
miss_handling_unit.sv
mhu_asserts.sv
tb_miss_handling_unit.sv
